/* hdl/rapid_pkg.sv */
package rapid_pkg;

    // Datapath width, fixed for the whole core
    localparam int XLEN = 32;

    // Widths with a meaning of their own
    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      shamt_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     instr_t;

    // Function field of the instruction, bits [14:12]
    // Branches reuse the same raw 3-bit codes
    typedef enum logic [2:0] {
        ADD_or_SUB = 3'b000,
        SLL        = 3'b001,
        SLT        = 3'b010,
        SLTU       = 3'b011,
        XOR_       = 3'b100,
        SRL_or_SRA = 3'b101,
        OR_        = 3'b110,
        AND_       = 3'b111
    } fcs_e;

    // Control bundle from decode into execute
    // One-hot block select, then the per-block flags
    typedef struct packed {
        logic      alu_imm;
        logic      alu_reg;
        logic      cond_branch;
        logic      uncond_branch;
        logic      load_upper_imm;
        logic      mem;
        // Inverted op: SUB, SRA, JALR, LUI, stores
        logic      iop;
        fcs_e      fcs_opcode;
        reg_addr_t rd;
        instr_t    debug_instruction;
    } control_ex_s;

    // Control bundle handed on to the memory stage
    typedef struct packed {
        logic      mem;
        logic      iop;
        fcs_e      fcs_opcode;
        reg_addr_t rd;
        instr_t    debug_instruction;
    } control_mem_s;

    // Everything execute needs for one instruction
    typedef struct packed {
        word_t       pc;
        word_t       rs1;
        word_t       rs2;
        word_t       imm;
        control_ex_s ctrl;
    } ex_operands_s;

    // Registered result toward the memory stage
    typedef struct packed {
        control_mem_s ctrl;
        word_t        rd_value;
        logic         pc_load;
        word_t        pc_ext;
        word_t        memory_data;
    } ex_result_s;

    // Execute sequencer states
    typedef enum logic [0:0] {
        EX_IDLE  = 1'b0,
        EX_SHIFT = 1'b1
    } ex_state_e;

endpackage

/* hdl/shift_unit.sv */
module shift_unit import rapid_pkg::*; (
    input  logic  i_clk,
    input  logic  i_arst_n,
    input  logic  i_load,
    input  logic  i_step,
    input  logic  i_left,
    input  logic  i_arith,
    input  word_t i_operand,
    output word_t o_value
);

    word_t value_q;
    logic  left_q;
    logic  arith_q;

    // Direction latched with the operand, held for the whole shift
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            left_q  <= 1'b0;
            arith_q <= 1'b0;
        end else if (i_load) begin
            left_q  <= i_left;
            arith_q <= i_arith;
        end
    end

    // One bit position per step
    always_ff @(posedge i_clk) begin
        if (i_load) begin
            value_q <= i_operand;
        end else if (i_step) begin
            if (left_q)
                value_q <= {value_q[XLEN-2:0], 1'b0};
            else
                // Sign fill for arithmetic, zero fill otherwise
                value_q <= {arith_q & value_q[XLEN-1], value_q[XLEN-1:1]};
        end
    end

    assign o_value = value_q;

endmodule

/* hdl/shift_counter.sv */
module shift_counter import rapid_pkg::*; (
    input  logic   i_clk,
    input  logic   i_arst_n,
    input  logic   i_load,
    input  logic   i_step,
    input  shamt_t i_count,
    output logic   o_zero
);

    // Bits still to shift
    shamt_t count_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            count_q <= '0;
        end else if (i_load) begin
            count_q <= i_count;
        end else if (i_step) begin
            // Never stepped at zero, so no wrap
            count_q <= count_q - 5'd1;
        end
    end

    // Straight from the count so the last step is seen in the same cycle
    assign o_zero = (count_q == '0);

endmodule

/* hdl/execute_logic.sv */
module execute_logic import rapid_pkg::*; (
    input  word_t        i_pc,
    input  control_ex_s  i_control_signal,
    input  word_t        i_rs1,
    input  word_t        i_rs2,
    input  word_t        i_imm,
    output control_mem_s o_control_signal,
    output logic         o_pc_load,
    output word_t        o_pc_ext,
    output word_t        o_memory_data,
    output word_t        o_rd_output,
    output logic         o_is_shift,
    output logic         o_shift_left,
    output logic         o_shift_arith,
    output shamt_t       o_shamt
);

    // Second ALU operand, register form or immediate form
    word_t port2;
    logic  is_alu;

    assign port2  = i_control_signal.alu_reg ? i_rs2 : i_imm;
    assign is_alu = i_control_signal.alu_imm || i_control_signal.alu_reg;

    // Store data is always rs2, loads simply ignore it
    assign o_memory_data = i_rs2;

    // Control fields that memory still needs
    assign o_control_signal.mem               = i_control_signal.mem;
    assign o_control_signal.iop               = i_control_signal.iop;
    assign o_control_signal.fcs_opcode        = i_control_signal.fcs_opcode;
    assign o_control_signal.rd                = i_control_signal.rd;
    assign o_control_signal.debug_instruction = i_control_signal.debug_instruction;

    // Shifts go to the serial unit
    assign o_is_shift    = is_alu && ((i_control_signal.fcs_opcode == SLL) ||
                                      (i_control_signal.fcs_opcode == SRL_or_SRA));
    assign o_shift_left  = (i_control_signal.fcs_opcode == SLL);
    // SRA/SRAI carry the inverted-op flag
    assign o_shift_arith = i_control_signal.iop;
    // Only the low five bits count, as the ISA says
    assign o_shamt       = port2[4:0];

    always_comb begin
        o_rd_output = '0;
        o_pc_ext    = '0;
        o_pc_load   = 1'b0;

        if (is_alu) begin
            // Register and immediate forms share the datapath
            case (i_control_signal.fcs_opcode)
                ADD_or_SUB: begin
                    // SUB only exists in register form
                    if (i_control_signal.iop)
                        o_rd_output = i_rs1 - port2;
                    else
                        o_rd_output = i_rs1 + port2;
                end
                SLT:  o_rd_output = word_t'($signed(i_rs1) < $signed(port2));
                SLTU: o_rd_output = word_t'(i_rs1 < port2);
                XOR_: o_rd_output = i_rs1 ^ port2;
                OR_:  o_rd_output = i_rs1 | port2;
                AND_: o_rd_output = i_rs1 & port2;
                // Result comes from the shifter, left at zero here
                default: o_rd_output = '0;
            endcase
        end else if (i_control_signal.cond_branch) begin
            // Raw funct3 codes of the branches
            case (i_control_signal.fcs_opcode)
                // BEQ
                3'b000:  o_pc_load = (i_rs1 == i_rs2);
                // BNE
                3'b001:  o_pc_load = (i_rs1 != i_rs2);
                // BLT
                3'b100:  o_pc_load = ($signed(i_rs1) < $signed(i_rs2));
                // BGE
                3'b101:  o_pc_load = ($signed(i_rs1) >= $signed(i_rs2));
                // BLTU
                3'b110:  o_pc_load = (i_rs1 < i_rs2);
                // BGEU
                3'b111:  o_pc_load = (i_rs1 >= i_rs2);
                // 010 and 011 are not branches
                default: o_pc_load = 1'b0;
            endcase
            // Target formed even when not taken
            o_pc_ext = i_pc + i_imm;
        end else if (i_control_signal.uncond_branch) begin
            // Link value
            o_rd_output = i_pc + 32'd4;
            // JALR is register based, JAL is pc relative
            if (i_control_signal.iop)
                o_pc_ext = i_rs1 + i_imm;
            else
                o_pc_ext = i_pc + i_imm;
            o_pc_load = 1'b1;
        end else if (i_control_signal.load_upper_imm) begin
            // Immediate arrives already shifted into the upper bits
            if (i_control_signal.iop)
                o_rd_output = i_imm;
            else
                o_rd_output = i_pc + i_imm;
        end else if (i_control_signal.mem) begin
            // Effective address for loads and stores
            o_rd_output = i_rs1 + i_imm;
        end
    end

endmodule

/* hdl/execute_fsm.sv */
module execute_fsm import rapid_pkg::*; (
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  logic         i_valid,
    input  ex_operands_s i_operands,
    input  logic         i_is_shift,
    input  logic         i_count_zero,
    output ex_operands_s o_operands,
    output logic         o_load,
    output logic         o_step,
    output logic         o_capture,
    output logic         o_capture_shift,
    output logic         o_busy
);

    ex_state_e    state_q;
    ex_state_e    state_d;
    logic         pending_q;
    logic         accept;
    ex_operands_s operands_q;

    // Busy from the cycle after acceptance until the capture edge
    assign o_busy = pending_q || (state_q == EX_SHIFT);
    // A pulse while busy is dropped
    assign accept = i_valid && !o_busy;

    // Operand register, held stable until capture
    always_ff @(posedge i_clk) begin
        if (accept)
            operands_q <= i_operands;
    end

    assign o_operands = operands_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q   <= EX_IDLE;
            pending_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            // Lives exactly one cycle, the one after the latch
            pending_q <= accept;
        end
    end

    always_comb begin
        state_d         = state_q;
        o_load          = 1'b0;
        o_step          = 1'b0;
        o_capture       = 1'b0;
        o_capture_shift = 1'b0;
        case (state_q)
            EX_IDLE: begin
                if (pending_q) begin
                    if (i_is_shift) begin
                        // Start shifter and counter together
                        o_load  = 1'b1;
                        state_d = EX_SHIFT;
                    end else begin
                        // Combinational result is ready now
                        o_capture = 1'b1;
                    end
                end
            end
            EX_SHIFT: begin
                if (i_count_zero) begin
                    o_capture       = 1'b1;
                    o_capture_shift = 1'b1;
                    state_d         = EX_IDLE;
                end else begin
                    o_step = 1'b1;
                end
            end
            default: state_d = EX_IDLE;
        endcase
    end

endmodule

/* hdl/ex_mem_register.sv */
module ex_mem_register import rapid_pkg::*; (
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_capture,
    input  logic       i_use_shift,
    input  ex_result_s i_comb,
    input  word_t      i_shift_value,
    output logic       o_valid,
    output ex_result_s o_result
);

    ex_result_s result_d;
    ex_result_s result_q;
    logic       valid_q;

    // Shift results replace only rd_value
    always_comb begin
        result_d = i_comb;
        if (i_use_shift)
            result_d.rd_value = i_shift_value;
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q  <= 1'b0;
            result_q <= '0;
        end else begin
            // One-cycle pulse per capture
            valid_q <= i_capture;
            // Bundle held until the next capture
            if (i_capture)
                result_q <= result_d;
        end
    end

    assign o_valid  = valid_q;
    assign o_result = result_q;

endmodule

/* hdl/execute_stage.sv */
module execute_stage import rapid_pkg::*; (
    input  logic         i_clk,
    input  logic         i_arst_n,
    input  logic         i_valid,
    input  ex_operands_s i_operands,
    output logic         o_valid,
    output logic         o_busy,
    output ex_result_s   o_result
);

    ex_operands_s operands;
    ex_result_s   comb_result;
    logic         is_shift;
    logic         shift_left;
    logic         shift_arith;
    shamt_t       shamt;
    logic         load;
    logic         step;
    logic         capture;
    logic         capture_shift;
    logic         count_zero;
    word_t        shift_value;

    // Sequencer and operand latch
    execute_fsm u_execute_fsm (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_valid         (i_valid),
        .i_operands      (i_operands),
        .i_is_shift      (is_shift),
        .i_count_zero    (count_zero),
        .o_operands      (operands),
        .o_load          (load),
        .o_step          (step),
        .o_capture       (capture),
        .o_capture_shift (capture_shift),
        .o_busy          (o_busy)
    );

    // Everything except shifts, settled one cycle after the latch
    execute_logic u_execute_logic (
        .i_pc             (operands.pc),
        .i_control_signal (operands.ctrl),
        .i_rs1            (operands.rs1),
        .i_rs2            (operands.rs2),
        .i_imm            (operands.imm),
        .o_control_signal (comb_result.ctrl),
        .o_pc_load        (comb_result.pc_load),
        .o_pc_ext         (comb_result.pc_ext),
        .o_memory_data    (comb_result.memory_data),
        .o_rd_output      (comb_result.rd_value),
        .o_is_shift       (is_shift),
        .o_shift_left     (shift_left),
        .o_shift_arith    (shift_arith),
        .o_shamt          (shamt)
    );

    // Serial shifter, rs1 is always the shifted operand
    shift_unit u_shift_unit (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_load    (load),
        .i_step    (step),
        .i_left    (shift_left),
        .i_arith   (shift_arith),
        .i_operand (operands.rs1),
        .o_value   (shift_value)
    );

    shift_counter u_shift_counter (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_load   (load),
        .i_step   (step),
        .i_count  (shamt),
        .o_zero   (count_zero)
    );

    // Output register toward memory
    ex_mem_register u_ex_mem_register (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_capture     (capture),
        .i_use_shift   (capture_shift),
        .i_comb        (comb_result),
        .i_shift_value (shift_value),
        .o_valid       (o_valid),
        .o_result      (o_result)
    );

endmodule

/* tb/exec_ref_tasks.svh */
`ifndef EXEC_REF_TASKS_SVH
`define EXEC_REF_TASKS_SVH

// Expected execute result from the RV32I instruction rules
function automatic ex_result_s model_result(input ex_operands_s op);
    ex_result_s             r;
    word_t                  b;
    word_t                  cmp;
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic [2:0]             f3;
    logic                   lt_s;
    logic                   lt_u;
    logic                   taken;
    r     = '0;
    f3    = op.ctrl.fcs_opcode;
    // I-type forms take the immediate as second source
    b     = op.ctrl.alu_reg ? op.rs2 : op.imm;
    // Branches always compare rs1 with rs2
    cmp   = op.ctrl.cond_branch ? op.rs2 : b;
    sa    = op.rs1;
    sb    = cmp;
    lt_s  = sa < sb;
    lt_u  = op.rs1 < cmp;
    taken = 1'b0;
    r.ctrl = {op.ctrl.mem, op.ctrl.iop, op.ctrl.fcs_opcode, op.ctrl.rd,
              op.ctrl.debug_instruction};
    r.memory_data = op.rs2;
    if (op.ctrl.alu_imm || op.ctrl.alu_reg) begin
        case (op.ctrl.fcs_opcode)
            ADD_or_SUB: r.rd_value = op.ctrl.iop ? op.rs1 - b : op.rs1 + b;
            SLL:        r.rd_value = op.rs1 << b[4:0];
            SLT:        r.rd_value = {31'b0, lt_s};
            SLTU:       r.rd_value = {31'b0, lt_u};
            XOR_:       r.rd_value = op.rs1 ^ b;
            OR_:        r.rd_value = op.rs1 | b;
            AND_:       r.rd_value = op.rs1 & b;
            SRL_or_SRA: begin
                // Only the low five bits of the amount count
                if (op.ctrl.iop)
                    r.rd_value = sa >>> b[4:0];
                else
                    r.rd_value = op.rs1 >> b[4:0];
            end
        endcase
    end else if (op.ctrl.cond_branch) begin
        // funct3[2:1] picks the compare
        // funct3[0] negates it
        case (f3[2:1])
            2'b00:   taken = (op.rs1 == op.rs2);
            2'b10:   taken = lt_s;
            2'b11:   taken = lt_u;
            default: taken = 1'b0;
        endcase
        r.pc_load = (f3[2:1] != 2'b01) && (taken ^ f3[0]);
        r.pc_ext  = op.pc + op.imm;
    end else if (op.ctrl.uncond_branch) begin
        r.rd_value = op.pc + 32'd4;
        r.pc_ext   = op.ctrl.iop ? op.rs1 + op.imm : op.pc + op.imm;
        r.pc_load  = 1'b1;
    end else if (op.ctrl.load_upper_imm) begin
        // LUI when iop is set and AUIPC otherwise
        r.rd_value = op.ctrl.iop ? op.imm : op.pc + op.imm;
    end else if (op.ctrl.mem) begin
        r.rd_value = op.rs1 + op.imm;
    end
    return r;
endfunction

// Present one instruction for a single cycle
task automatic send_instr(input ex_operands_s op);
    @(posedge i_clk);
    i_operands <= op;
    i_valid    <= 1'b1;
    @(posedge i_clk);
    i_valid    <= 1'b0;
endtask

// Wait for o_valid and check that busy stays high until then
task automatic wait_result(input string name, output int cycles, output logic seen);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 40) begin
        @(negedge i_clk);
        cycles++;
        if (o_valid) begin
            seen = 1'b1;
            assert (!o_busy) else report_fail(name, "o_busy", 64'd0, {63'b0, o_busy});
        end else begin
            assert (o_busy) else report_fail(name, "o_busy", 64'd1, {63'b0, o_busy});
        end
    end
    assert (seen) else begin
        $display("%s: no o_valid within 40 cycles", name);
        errors++;
    end
endtask

`endif

/* tb/tb_execute_stage.sv */
module tb_execute_stage import rapid_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;
    // Instructions issued by all tests together
    localparam int NUM_INSTR  = 123;

    // Block selects in control_ex_s field order
    localparam logic [5:0] SEL_ALU_IMM = 6'b100000;
    localparam logic [5:0] SEL_ALU_REG = 6'b010000;
    localparam logic [5:0] SEL_BRANCH  = 6'b001000;
    localparam logic [5:0] SEL_JUMP    = 6'b000100;
    localparam logic [5:0] SEL_UPPER   = 6'b000010;
    localparam logic [5:0] SEL_MEM     = 6'b000001;

    logic         i_clk;
    logic         i_arst_n;
    logic         i_valid;
    ex_operands_s i_operands;
    logic         o_valid;
    logic         o_busy;
    ex_result_s   o_result;

    integer seed   = 13;
    int     errors = 0;
    int     checks = 0;

    execute_stage u_execute_stage (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_valid    (i_valid),
        .i_operands (i_operands),
        .o_valid    (o_valid),
        .o_busy     (o_busy),
        .o_result   (o_result)
    );

    `include "exec_ref_tasks.svh"

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Forty cycles allowed per instruction
    initial begin
        #(NUM_INSTR * 40 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // Random pc, rd and debug word around the given operands
    function automatic ex_operands_s make_op(input logic [5:0] sel, input logic iop,
                                             input fcs_e f, input word_t rs1,
                                             input word_t rs2, input word_t imm);
        ex_operands_s op;
        word_t        r;
        r      = $random(seed);
        op.pc  = {r[31:2], 2'b00};
        op.rs1 = rs1;
        op.rs2 = rs2;
        op.imm = imm;
        {op.ctrl.alu_imm, op.ctrl.alu_reg, op.ctrl.cond_branch, op.ctrl.uncond_branch,
         op.ctrl.load_upper_imm, op.ctrl.mem} = sel;
        op.ctrl.iop               = iop;
        op.ctrl.fcs_opcode        = f;
        op.ctrl.rd                = r[6:2];
        op.ctrl.debug_instruction = $random(seed);
        return op;
    endfunction

    task automatic report_fail(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        $display("FAIL %s %s expected %0h actual %0h", name, field, exp, act);
        errors++;
    endtask

    task automatic check_result(input string name, input ex_operands_s op);
        ex_result_s exp;
        exp = model_result(op);
        checks++;
        assert (o_result.ctrl == exp.ctrl)
            else report_fail(name, "ctrl", {22'b0, exp.ctrl}, {22'b0, o_result.ctrl});
        assert (o_result.memory_data == exp.memory_data)
            else report_fail(name, "memory_data", {32'b0, exp.memory_data},
                             {32'b0, o_result.memory_data});
        assert (o_result.pc_load == exp.pc_load)
            else report_fail(name, "pc_load", {63'b0, exp.pc_load}, {63'b0, o_result.pc_load});
        // Branches write no register
        if (!op.ctrl.cond_branch) begin
            assert (o_result.rd_value == exp.rd_value)
                else report_fail(name, "rd_value", {32'b0, exp.rd_value},
                                 {32'b0, o_result.rd_value});
        end
        if (op.ctrl.cond_branch || op.ctrl.uncond_branch) begin
            assert (o_result.pc_ext == exp.pc_ext)
                else report_fail(name, "pc_ext", {32'b0, exp.pc_ext}, {32'b0, o_result.pc_ext});
        end
    endtask

    task automatic run_instr(input string name, input ex_operands_s op, output int lat);
        logic seen;
        send_instr(op);
        wait_result(name, lat, seen);
        if (seen)
            check_result(name, op);
    endtask

    task automatic end_test(input string name, input int errs0);
        $display("%s: done, %0d errors", name, errors - errs0);
    endtask

    task automatic check_reset();
        ex_operands_s op;
        int           errs0;
        int           lat;
        errs0 = errors;
        @(negedge i_clk);
        assert (!o_valid) else report_fail("reset", "o_valid", 64'd0, {63'b0, o_valid});
        assert (!o_busy) else report_fail("reset", "o_busy", 64'd0, {63'b0, o_busy});
        assert (o_result == '0) else begin
            $display("FAIL reset o_result expected 0 actual %h", o_result);
            errors++;
        end
        // Latch edge then capture edge
        op = make_op(SEL_ALU_REG, 1'b0, ADD_or_SUB, 32'd7, 32'd5, 32'd0);
        run_instr("reset", op, lat);
        assert (lat == 2) else report_fail("reset", "latency", 64'd2, 64'(lat));
        end_test("reset", errs0);
    endtask

    task automatic run_alu_ops();
        ex_operands_s op;
        word_t        a [4];
        word_t        b [4];
        int           errs0;
        int           lat;
        errs0 = errors;
        a = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h0, 32'h0};
        b = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFF6, 32'h0};
        a[2] = $random(seed);
        a[3] = $random(seed);
        b[3] = $random(seed);
        for (int k = 0; k < 8; k++) begin
            if (k == 1 || k == 5)
                continue;
            // Form 0 register, 1 immediate, 2 SUB
            for (int form = 0; form < 3; form++) begin
                if (form == 2 && k != 0)
                    continue;
                for (int v = 0; v < 4; v++) begin
                    // The unused source holds the complement of the used one
                    op = make_op(form == 1 ? SEL_ALU_IMM : SEL_ALU_REG, form == 2,
                                 fcs_e'(k[2:0]), a[v], form == 1 ? ~b[v] : b[v],
                                 form == 1 ? b[v] : ~b[v]);
                    run_instr("alu", op, lat);
                end
            end
        end
        end_test("alu", errs0);
    endtask

    task automatic run_shifts();
        ex_operands_s op;
        shamt_t       amt [5];
        word_t        upper;
        word_t        count;
        int           errs0;
        int           lat;
        errs0 = errors;
        amt = '{5'd0, 5'd1, 5'd17, 5'd31, 5'd0};
        amt[4] = shamt_t'($random(seed));
        // SLL, SRL, then SRA
        for (int s = 0; s < 3; s++) begin
            for (int form = 0; form < 2; form++) begin
                for (int v = 0; v < 5; v++) begin
                    // Upper bits of the amount must be ignored
                    upper = $random(seed);
                    count = {upper[31:5], amt[v]};
                    // The unused source carries a different amount
                    op = make_op(form == 1 ? SEL_ALU_IMM : SEL_ALU_REG, s == 2,
                                 s == 0 ? SLL : SRL_or_SRA, $random(seed),
                                 form == 1 ? ~count : count, form == 1 ? count : ~count);
                    run_instr("shift", op, lat);
                end
            end
        end
        end_test("shift", errs0);
    endtask

    task automatic busy_drop();
        ex_operands_s op;
        ex_operands_s extra;
        int           errs0;
        int           pulses;
        errs0  = errors;
        pulses = 0;
        op    = make_op(SEL_ALU_IMM, 1'b1, SRL_or_SRA, 32'h8421_F00F, 32'h0, 32'd17);
        extra = make_op(SEL_ALU_REG, 1'b0, ADD_or_SUB, 32'd1, 32'd2, 32'd0);
        @(posedge i_clk);
        i_operands <= op;
        i_valid    <= 1'b1;
        @(posedge i_clk);
        // Second pulse arrives while busy
        i_operands <= extra;
        i_valid    <= 1'b1;
        @(posedge i_clk);
        i_valid    <= 1'b0;
        repeat (60) begin
            @(negedge i_clk);
            if (o_valid) begin
                pulses++;
                check_result("busy", op);
            end else if (pulses == 0) begin
                assert (o_busy) else report_fail("busy", "o_busy", 64'd1, {63'b0, o_busy});
            end
        end
        assert (pulses == 1) else report_fail("busy", "o_valid pulses", 64'd1, 64'(pulses));
        end_test("busy", errs0);
    endtask

    task automatic run_branches();
        ex_operands_s op;
        logic [2:0]   codes [6];
        word_t        a [4];
        word_t        b [4];
        int           errs0;
        int           lat;
        errs0 = errors;
        codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // Equal, signed and unsigned order disagree, sign boundary, random
        a = '{32'd5, 32'hFFFF_FFFF, 32'd3, 32'h0};
        b = '{32'd5, 32'd1, 32'h8000_0000, 32'h0};
        a[3] = $random(seed);
        b[3] = $random(seed);
        for (int c = 0; c < 6; c++) begin
            for (int v = 0; v < 4; v++) begin
                op = make_op(SEL_BRANCH, 1'b0, fcs_e'(codes[c]), a[v], b[v], $random(seed));
                run_instr("branch", op, lat);
            end
        end
        end_test("branch", errs0);
    endtask

    task automatic run_jumps_upper();
        ex_operands_s op;
        word_t        imm;
        int           errs0;
        int           lat;
        errs0 = errors;
        for (int v = 0; v < 2; v++) begin
            imm = $random(seed);
            // JAL then JALR
            op = make_op(SEL_JUMP, 1'b0, ADD_or_SUB, $random(seed), $random(seed), imm);
            run_instr("jump", op, lat);
            op = make_op(SEL_JUMP, 1'b1, ADD_or_SUB, $random(seed), $random(seed), imm);
            run_instr("jump", op, lat);
            imm = {imm[31:12], 12'h000};
            // LUI then AUIPC
            op = make_op(SEL_UPPER, 1'b1, ADD_or_SUB, $random(seed), $random(seed), imm);
            run_instr("upper", op, lat);
            op = make_op(SEL_UPPER, 1'b0, ADD_or_SUB, $random(seed), $random(seed), imm);
            run_instr("upper", op, lat);
        end
        end_test("jump_upper", errs0);
    endtask

    task automatic run_loads_stores();
        ex_operands_s op;
        int           errs0;
        int           lat;
        errs0 = errors;
        // Byte, half and word widths
        for (int v = 0; v < 3; v++) begin
            op = make_op(SEL_MEM, 1'b0, fcs_e'(v[2:0]), $random(seed), $random(seed),
                         $random(seed));
            run_instr("load", op, lat);
            op = make_op(SEL_MEM, 1'b1, fcs_e'(v[2:0]), $random(seed), $random(seed),
                         $random(seed));
            run_instr("store", op, lat);
        end
        end_test("load_store", errs0);
    endtask

    initial begin
        i_arst_n   = 1'b0;
        i_valid    = 1'b0;
        i_operands = '0;
        repeat (2) @(posedge i_clk);
        i_arst_n <= 1'b1;
        check_reset();
        run_alu_ops();
        run_shifts();
        busy_drop();
        run_branches();
        run_jumps_upper();
        run_loads_stores();
        $display("%0d results checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+tb
hdl/rapid_pkg.sv
hdl/shift_unit.sv
hdl/shift_counter.sv
hdl/execute_logic.sv
hdl/execute_fsm.sv
hdl/ex_mem_register.sv
hdl/execute_stage.sv
tb/tb_execute_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_execute_stage -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_execute_stage)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
